// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := cond_alu_tb
FILELIST  := cond_alu.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := FAIL: see errors above
PASS_MSG  := PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation stopped early"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== alu_high.sv ====
/*
  Stage 3 of the conditional ALU. Finishes the high half with the carry
  from the low half, joins both halves and derives C, V, N and Z. When the
  condition failed the else value and the incoming flags are registered
  instead.
*/
`timescale 1ns/1ns

module alu_high import alu_pkg::*; #(
  parameter int DATA_W = 64
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                s2_valid,
  input  op_t                 s2_op,
  input  logic                s2_exec,
  input  logic [DATA_W-1:0]   s2_a,
  input  logic [DATA_W-1:0]   s2_b,
  input  logic [DATA_W-1:0]   s2_else,
  input  logic [3:0]          s2_flags,
  input  logic [DATA_W/2-1:0] s2_lo,
  input  logic                s2_carry,
  output logic                out_valid,
  output logic [DATA_W-1:0]   result,
  output logic [3:0]          flags_out
);

  localparam int HALF_W = DATA_W / 2;
  localparam int SX8  = DATA_W - 8;
  localparam int SX16 = DATA_W - 16;
  localparam int SX32 = (DATA_W > 32) ? DATA_W - 32 : 0;

  logic [HALF_W-1:0] a_hi;
  logic [HALF_W-1:0] b_hi;
  logic [HALF_W-1:0] sum_hi;
  logic              cout;
  logic              ovf;
  logic              is_arith;
  logic [5:0]        shamt;
  logic [DATA_W-1:0] shl;
  logic [DATA_W-1:0] shr;
  logic [DATA_W-1:0] sar;
  logic [DATA_W-1:0] sx8;
  logic [DATA_W-1:0] sx16;
  logic [DATA_W-1:0] sx32;
  logic [HALF_W-1:0] hi;
  logic [DATA_W-1:0] res;
  logic [3:0]        flags;

  assign a_hi = s2_a[DATA_W-1:HALF_W];
  assign b_hi = (s2_op == OP_SUB) ? ~s2_b[DATA_W-1:HALF_W] : s2_b[DATA_W-1:HALF_W];
  assign {cout, sum_hi} = {1'b0, a_hi} + {1'b0, b_hi} + {{HALF_W{1'b0}}, s2_carry};
  // operands agree in sign but the sum does not
  assign ovf      = (a_hi[HALF_W-1] == b_hi[HALF_W-1]) && (sum_hi[HALF_W-1] != a_hi[HALF_W-1]);
  assign is_arith = (s2_op == OP_ADD) || (s2_op == OP_SUB);

  assign shamt = 6'(s2_b[5:0] % DATA_W);
  assign shl   = s2_a << shamt;
  assign shr   = s2_a >> shamt;
  assign sar   = $signed(s2_a) >>> shamt;

  assign sx8  = $signed(s2_a << SX8) >>> SX8;
  assign sx16 = $signed(s2_a << SX16) >>> SX16;
  assign sx32 = $signed(s2_a << SX32) >>> SX32;

  always_comb begin
    case (s2_op)
      OP_ADD, OP_SUB: hi = sum_hi;
      OP_AND:   hi = a_hi & s2_b[DATA_W-1:HALF_W];
      OP_XOR:   hi = a_hi ^ s2_b[DATA_W-1:HALF_W];
      OP_OR:    hi = a_hi | s2_b[DATA_W-1:HALF_W];
      OP_SHL:   hi = shl[DATA_W-1:HALF_W];
      OP_SHR:   hi = shr[DATA_W-1:HALF_W];
      OP_SAR:   hi = sar[DATA_W-1:HALF_W];
      OP_SXT8:  hi = sx8[DATA_W-1:HALF_W];  // sign fill
      OP_SXT16: hi = sx16[DATA_W-1:HALF_W];
      OP_SXT32: hi = sx32[DATA_W-1:HALF_W];
      default:  hi = s2_b[DATA_W-1:HALF_W];
    endcase
  end

  assign res = {hi, s2_lo};

  always_comb begin
    flags         = '0;
    flags[FLAG_C] = is_arith & cout;
    flags[FLAG_V] = is_arith & ovf;
    flags[FLAG_N] = res[DATA_W-1];
    flags[FLAG_Z] = (res == '0);
  end

  always_ff @(posedge clk) begin
    if (rst) out_valid <= 1'b0;
    else     out_valid <= s2_valid;
  end

  always_ff @(posedge clk) begin
    result    <= s2_exec ? res : s2_else;
    flags_out <= s2_exec ? flags : s2_flags;  // failed condition keeps flags
  end

endmodule

// ==== alu_issue.sv ====
/*
  Stage 1 of the conditional ALU. Captures an operation when in_valid is
  high, picks the immediate or b as operand B, evaluates the condition
  against the incoming flags and expands the else select to a full word.
*/
`timescale 1ns/1ns

module alu_issue import alu_pkg::*; #(
  parameter int DATA_W = 64
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  op_t               op,
  input  cond_t             cond,
  input  else_t             else_sel,
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  input  logic [DATA_W-1:0] imm,
  input  logic              use_imm,
  input  logic [3:0]        flags_in,
  output logic              s1_valid,
  output op_t               s1_op,
  output logic              s1_exec,
  output logic [DATA_W-1:0] s1_a,
  output logic [DATA_W-1:0] s1_b,
  output logic [DATA_W-1:0] s1_else,
  output logic [3:0]        s1_flags
);

  logic [DATA_W-1:0] opnd_b;
  logic [DATA_W-1:0] else_val;
  logic              exec;

  assign opnd_b = use_imm ? imm : b;
  assign exec   = cond_true(cond, flags_in);

  always_comb begin
    case (else_sel)
      ELSE_A:    else_val = a;
      ELSE_ONE:  else_val = {{(DATA_W-1){1'b0}}, 1'b1};
      ELSE_ZERO: else_val = '0;
      default:   else_val = '1;  // ELSE_ONES
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    s1_op    <= op;
    s1_exec  <= exec;
    s1_a     <= a;
    s1_b     <= opnd_b;
    s1_else  <= else_val;
    s1_flags <= flags_in;
  end

endmodule

// ==== alu_low.sv ====
/*
  Stage 2 of the conditional ALU. Produces the low half of the result and
  the carry out of the low-half add or subtract. Shifts work on the full
  word so right shifts pull in upper bits. Operands are passed on so the
  next stage can finish the high half.
*/
`timescale 1ns/1ns

module alu_low import alu_pkg::*; #(
  parameter int DATA_W = 64
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                s1_valid,
  input  op_t                 s1_op,
  input  logic                s1_exec,
  input  logic [DATA_W-1:0]   s1_a,
  input  logic [DATA_W-1:0]   s1_b,
  input  logic [DATA_W-1:0]   s1_else,
  input  logic [3:0]          s1_flags,
  output logic                s2_valid,
  output op_t                 s2_op,
  output logic                s2_exec,
  output logic [DATA_W-1:0]   s2_a,
  output logic [DATA_W-1:0]   s2_b,
  output logic [DATA_W-1:0]   s2_else,
  output logic [3:0]          s2_flags,
  output logic [DATA_W/2-1:0] s2_lo,
  output logic                s2_carry
);

  localparam int HALF_W = DATA_W / 2;
  // left shift that puts the source sign bit at the top
  localparam int SX8  = DATA_W - 8;
  localparam int SX16 = DATA_W - 16;
  localparam int SX32 = (DATA_W > 32) ? DATA_W - 32 : 0;

  logic              is_sub;
  logic [DATA_W-1:0] b_op;
  logic [HALF_W-1:0] sum_lo;
  logic              cout;
  logic [5:0]        shamt;
  logic [DATA_W-1:0] shl;
  logic [DATA_W-1:0] shr;
  logic [DATA_W-1:0] sar;
  logic [DATA_W-1:0] sx8;
  logic [DATA_W-1:0] sx16;
  logic [DATA_W-1:0] sx32;
  logic [HALF_W-1:0] lo;

  assign is_sub = (s1_op == OP_SUB);
  assign b_op   = is_sub ? ~s1_b : s1_b;  // a - b as a + ~b + 1
  assign {cout, sum_lo} = {1'b0, s1_a[HALF_W-1:0]} + {1'b0, b_op[HALF_W-1:0]}
                        + {{HALF_W{1'b0}}, is_sub};

  assign shamt = 6'(s1_b[5:0] % DATA_W);
  assign shl   = s1_a << shamt;
  assign shr   = s1_a >> shamt;
  assign sar   = $signed(s1_a) >>> shamt;

  assign sx8  = $signed(s1_a << SX8) >>> SX8;
  assign sx16 = $signed(s1_a << SX16) >>> SX16;
  assign sx32 = $signed(s1_a << SX32) >>> SX32;

  always_comb begin
    case (s1_op)
      OP_ADD, OP_SUB: lo = sum_lo;
      OP_AND:   lo = s1_a[HALF_W-1:0] & s1_b[HALF_W-1:0];
      OP_XOR:   lo = s1_a[HALF_W-1:0] ^ s1_b[HALF_W-1:0];
      OP_OR:    lo = s1_a[HALF_W-1:0] | s1_b[HALF_W-1:0];
      OP_SHL:   lo = shl[HALF_W-1:0];
      OP_SHR:   lo = shr[HALF_W-1:0];
      OP_SAR:   lo = sar[HALF_W-1:0];
      OP_SXT8:  lo = sx8[HALF_W-1:0];
      OP_SXT16: lo = sx16[HALF_W-1:0];
      OP_SXT32: lo = sx32[HALF_W-1:0];
      default:  lo = s1_b[HALF_W-1:0];  // move
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) s2_valid <= 1'b0;
    else     s2_valid <= s1_valid;
  end

  always_ff @(posedge clk) begin
    s2_op    <= s1_op;
    s2_exec  <= s1_exec;
    s2_a     <= s1_a;
    s2_b     <= s1_b;
    s2_else  <= s1_else;
    s2_flags <= s1_flags;
    s2_lo    <= lo;
    s2_carry <= cout;  // only meaningful for add/sub
  end

endmodule

// ==== alu_pkg.sv ====
/*
  Shared types for the conditional ALU pipeline: opcodes, condition codes,
  else-value selects and flag bit positions, plus the condition evaluator.
  Every pipeline stage and the testbench import this package.
*/
package alu_pkg;

  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_AND   = 4'd2,
    OP_XOR   = 4'd3,
    OP_OR    = 4'd4,
    OP_SHL   = 4'd5,
    OP_SHR   = 4'd6,
    OP_SAR   = 4'd7,
    OP_SXT8  = 4'd8,
    OP_SXT16 = 4'd9,
    OP_SXT32 = 4'd10,
    OP_MOV   = 4'd11  // 12..15 decode as move
  } op_t;

  typedef enum logic [3:0] {
    C_EQ, C_NE, C_CS, C_CC, C_MI, C_PL, C_VS, C_VC,
    C_HI, C_LS, C_GE, C_LT, C_GT, C_LE, C_AL, C_NV
  } cond_t;

  typedef enum logic [1:0] {
    ELSE_A    = 2'd0,
    ELSE_ONE  = 2'd1,
    ELSE_ZERO = 2'd2,
    ELSE_ONES = 2'd3
  } else_t;

  // positions in the 4-bit flags word
  localparam int FLAG_C = 3;
  localparam int FLAG_V = 2;
  localparam int FLAG_N = 1;
  localparam int FLAG_Z = 0;

  function automatic logic cond_true(cond_t c, logic [3:0] f);
    logic z;
    logic n;
    logic v;
    logic cy;
    z  = f[FLAG_Z];
    n  = f[FLAG_N];
    v  = f[FLAG_V];
    cy = f[FLAG_C];
    case (c)
      C_EQ: return z;
      C_NE: return !z;
      C_CS: return cy;
      C_CC: return !cy;
      C_MI: return n;
      C_PL: return !n;
      C_VS: return v;
      C_VC: return !v;
      C_HI: return cy && !z;  // unsigned higher
      C_LS: return !cy || z;
      C_GE: return n == v;
      C_LT: return n != v;
      C_GT: return !z && (n == v);
      C_LE: return z || (n != v);
      C_AL: return 1'b1;
      default: return 1'b0;  // C_NV
    endcase
  endfunction

endpackage

// ==== cond_alu.f ====
alu_pkg.sv
alu_issue.sv
alu_low.sv
alu_high.sv
cond_alu.sv
tb_clock.sv
cond_alu_properties.sv
cond_alu_tb.sv

// ==== cond_alu.sv ====
/*
  Conditional integer execute pipeline. Three stages chained back to back
  with a fixed latency of three cycles and no back-pressure. Every beat with
  in_valid high comes out once on out_valid. DATA_W is set here.
*/
`timescale 1ns/1ns

module cond_alu import alu_pkg::*; #(
  parameter int DATA_W = 64
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  op_t               op,
  input  cond_t             cond,
  input  else_t             else_sel,
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  input  logic [DATA_W-1:0] imm,
  input  logic              use_imm,
  input  logic [3:0]        flags_in,
  output logic              out_valid,
  output logic [DATA_W-1:0] result,
  output logic [3:0]        flags_out
);

  // issue to low
  logic              s1_valid;
  op_t               s1_op;
  logic              s1_exec;
  logic [DATA_W-1:0] s1_a;
  logic [DATA_W-1:0] s1_b;
  logic [DATA_W-1:0] s1_else;
  logic [3:0]        s1_flags;

  // low to high
  logic                s2_valid;
  op_t                 s2_op;
  logic                s2_exec;
  logic [DATA_W-1:0]   s2_a;
  logic [DATA_W-1:0]   s2_b;
  logic [DATA_W-1:0]   s2_else;
  logic [3:0]          s2_flags;
  logic [DATA_W/2-1:0] s2_lo;
  logic                s2_carry;

  alu_issue #(.DATA_W(DATA_W)) issue_i (.*);

  alu_low #(.DATA_W(DATA_W)) low_i (.*);

  alu_high #(.DATA_W(DATA_W)) high_i (.*);

endmodule

// ==== cond_alu_properties.sv ====
/*
  Concurrent checks on the conditional ALU, bound into cond_alu from the
  testbench. Covers the reset state of out_valid, the fixed three-cycle
  valid latency and flag pass-through when the condition failed.
*/
`timescale 1ns/1ns

module cond_alu_properties (
  input logic       clk,
  input logic       rst,
  input logic       in_valid,
  input logic [3:0] flags_in,
  input logic       s2_exec,
  input logic       out_valid,
  input logic [3:0] flags_out
);

  a_reset_quiet: assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high while reset is applied");

  // one more quiet cycle after release
  a_release_quiet: assert property (@(posedge clk) $fell(rst) |=> !out_valid)
    else $error("out_valid high on the cycle after reset release");

  a_latency: assert property (@(posedge clk) disable iff (rst)
    out_valid == $past(in_valid, 3))
    else $error("out_valid does not follow in_valid by three cycles");

  a_keep_flags: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !$past(s2_exec)) |-> (flags_out == $past(flags_in, 3)))
    else $error("flags_out changed although the condition failed");

endmodule

// ==== cond_alu_tb.sv ====
/*
  Testbench for the conditional ALU pipeline. Runs directed add/sub,
  logic, shift, extend and move beats, sweeps every condition code against
  every flags pattern and else select, then a random stream with gaps.
  Expected words come from a reference model and are compared in order.
*/
`timescale 1ns/1ns

module cond_alu_tb import alu_pkg::*; ();

  localparam int           W       = 64;
  localparam logic [W-1:0] LATENCY = 3;

  logic         clk;
  logic         rst;
  logic         in_valid;
  op_t          op;
  cond_t        cond;
  else_t        else_sel;
  logic [W-1:0] a;
  logic [W-1:0] b;
  logic [W-1:0] imm;
  logic         use_imm;
  logic [3:0]   flags_in;
  logic         out_valid;
  logic [W-1:0] result;
  logic [3:0]   flags_out;

  integer       seed = 32'h6f9b741f;
  logic [W+3:0] exp_q[$];  // {flags, result}
  logic [W-1:0] edge_q[$];
  logic [W-1:0] edge_cnt = '0;
  int           n_sent = 0;
  int           n_checked = 0;

  tb_clock #(.PERIOD(20), .RESET_CYCLES(5)) clock_i (.clk(clk), .rst(rst));

  cond_alu #(.DATA_W(W)) dut_i (.*);

  bind cond_alu cond_alu_properties props_i (
    .clk(clk),
    .rst(rst),
    .in_valid(in_valid),
    .flags_in(flags_in),
    .s2_exec(s2_exec),
    .out_valid(out_valid),
    .flags_out(flags_out)
  );

  task automatic stop_on_failure();
    $display("FAIL: see errors above");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check(string name, logic [W-1:0] got, logic [W-1:0] want);
    if (got !== want) begin
      $display("[FAIL] t=%0t %s: got %h expected %h", $time, name, got, want);
      stop_on_failure();
    end
  endtask

  function automatic logic [W-1:0] rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic logic cond_holds(logic [3:0] code, logic [3:0] f);
    logic z;
    logic n;
    logic v;
    logic c;
    logic base;
    z = f[FLAG_Z];
    n = f[FLAG_N];
    v = f[FLAG_V];
    c = f[FLAG_C];
    case (code[3:1])
      3'd0: base = z;
      3'd1: base = c;
      3'd2: base = n;
      3'd3: base = v;
      3'd4: base = c & ~z;
      3'd5: base = (n == v);
      3'd6: base = ~z & (n == v);
      default: base = 1'b1;
    endcase
    return base ^ code[0];  // odd codes negate the even ones
  endfunction

  function automatic logic [W+3:0] model_alu(op_t op_v, cond_t cond_v, else_t else_v,
      logic [W-1:0] a_v, logic [W-1:0] b_v, logic [W-1:0] imm_v, logic use_imm_v,
      logic [3:0] f_v);
    logic [W-1:0] opb;
    logic [W-1:0] r;
    logic [W:0]   wide;
    logic [3:0]   f;
    int           sh;
    opb = use_imm_v ? imm_v : b_v;
    if (!cond_holds(cond_v, f_v)) begin
      case (else_v)
        ELSE_A:    r = a_v;
        ELSE_ONE:  r = W'(1);
        ELSE_ZERO: r = '0;
        default:   r = '1;
      endcase
      return {f_v, r};
    end
    f = '0;
    wide = '0;
    sh = int'(opb[5:0]) % W;
    case (op_v)
      OP_ADD: begin
        wide = {1'b0, a_v} + {1'b0, opb};
        f[FLAG_V] = (a_v[W-1] == opb[W-1]) && (wide[W-1] != a_v[W-1]);
      end
      OP_SUB: begin
        wide = {1'b0, a_v} + {1'b0, ~opb} + {{W{1'b0}}, 1'b1};
        f[FLAG_V] = (a_v[W-1] != opb[W-1]) && (wide[W-1] != a_v[W-1]);
      end
      OP_AND:   wide[W-1:0] = a_v & opb;
      OP_XOR:   wide[W-1:0] = a_v ^ opb;
      OP_OR:    wide[W-1:0] = a_v | opb;
      OP_SHL:   wide[W-1:0] = a_v << sh;
      OP_SHR:   wide[W-1:0] = a_v >> sh;
      OP_SAR:   wide[W-1:0] = $signed(a_v) >>> sh;
      OP_SXT8:  wide[W-1:0] = {{(W-8){a_v[7]}}, a_v[7:0]};
      OP_SXT16: wide[W-1:0] = {{(W-16){a_v[15]}}, a_v[15:0]};
      OP_SXT32: wide[W-1:0] = {{(W-32){a_v[31]}}, a_v[31:0]};
      default:  wide[W-1:0] = opb;  // move and unused codes
    endcase
    r = wide[W-1:0];
    if (op_v == OP_ADD || op_v == OP_SUB) f[FLAG_C] = wide[W];
    f[FLAG_N] = r[W-1];
    f[FLAG_Z] = (r == '0);
    return {f, r};
  endfunction

  task automatic send(op_t op_v, cond_t cond_v, else_t else_v, logic [W-1:0] a_v,
      logic [W-1:0] b_v, logic [W-1:0] imm_v, logic use_imm_v, logic [3:0] f_v);
    @(posedge clk);
    in_valid <= 1'b1;
    op       <= op_v;
    cond     <= cond_v;
    else_sel <= else_v;
    a        <= a_v;
    b        <= b_v;
    imm      <= imm_v;
    use_imm  <= use_imm_v;
    flags_in <= f_v;
  endtask

  task automatic idle(int n);
    repeat (n) begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (rst && n < 50) begin
      @(posedge clk);
      n++;
    end
    if (rst) begin
      $display("timeout: reset was never released");
      stop_on_failure();
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d results never came out of the pipeline", exp_q.size());
      stop_on_failure();
    end
  endtask

  task automatic run_arith();
    logic [W-1:0] av [8];
    logic [W-1:0] bv [8];
    logic [W-1:0] junk;
    // carry across the halves, wrap to zero, both overflow directions
    av = '{64'h0000_0000_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF, 64'h7FFF_FFFF_FFFF_FFFF,
           64'h8000_0000_0000_0000, 64'h0000_0001_0000_0000, 64'h7FFF_FFFF_FFFF_FFFF,
           64'h0, 64'h1234_5678_9ABC_DEF0};
    bv = '{64'h1, 64'h1, 64'h1, 64'h1, 64'h1, 64'hFFFF_FFFF_FFFF_FFFF,
           64'h1, 64'h8765_4321_0FED_CBA9};
    for (int i = 0; i < 8; i++) begin
      for (int s = 0; s < 2; s++) begin
        for (int u = 0; u < 2; u++) begin
          junk = rand_word();
          send((s == 1) ? OP_SUB : OP_ADD, C_AL, ELSE_ZERO, av[i],
               u[0] ? junk : bv[i], u[0] ? bv[i] : junk, u[0], 4'(i));
        end
      end
    end
  endtask

  task automatic run_ops();
    logic [W-1:0] av [4];
    int           amts [4];
    logic [W-1:0] bw;
    logic [W-1:0] junk;
    av = '{64'h0000_0000_0000_0080, 64'h0000_0000_8000_7F00,
           64'hFFFF_FFFF_7FFF_FFFF, 64'h8123_4567_89AB_CDEF};
    amts = '{0, 31, 32, 63};
    for (int k = 5; k <= 7; k++) begin
      for (int j = 0; j < 4; j++) begin
        for (int i = 0; i < 4; i++) begin
          bw = rand_word();  // junk above the amount bits
          bw[5:0] = 6'(amts[i]);
          junk = rand_word();
          send(op_t'(4'(k)), C_AL, ELSE_A, av[j], i[0] ? junk : bw,
               i[0] ? bw : junk, i[0], 4'h0);
        end
      end
    end
    for (int k = 0; k < 16; k++) begin
      for (int j = 0; j < 4; j++) begin
        bw = (j == 3) ? av[j] : rand_word();  // xor of equal words hits Z
        if (k < 5 || k > 7) send(op_t'(4'(k)), C_AL, ELSE_A, av[j], bw, ~bw, 1'b0, 4'hF);
      end
    end
  endtask

  task automatic run_cond_sweep();
    for (int c = 0; c < 16; c++) begin
      for (int f = 0; f < 16; f++) begin
        for (int e = 0; e < 4; e++) begin
          send(op_t'(4'(e * 3)), cond_t'(4'(c)), else_t'(2'(e)), rand_word(),
               rand_word(), rand_word(), 1'b0, 4'(f));
        end
      end
    end
  endtask

  task automatic run_random(int beats);
    logic [31:0] r;
    for (int i = 0; i < beats; i++) begin
      r = $random(seed);
      if (r[1:0] == 2'b00) idle(1 + int'(r[3:2]));
      send(op_t'(r[7:4]), cond_t'(r[11:8]), else_t'(r[13:12]), rand_word(),
           rand_word(), rand_word(), r[14], r[19:16]);
    end
  endtask

  // accepted beats, as the DUT samples them
  always @(posedge clk) begin
    edge_cnt <= edge_cnt + W'(1);
    if (!rst && in_valid) begin
      exp_q.push_back(model_alu(op, cond, else_sel, a, b, imm, use_imm, flags_in));
      edge_q.push_back(edge_cnt);  // edge that drove the beat
      n_sent++;
    end
  end

  always @(negedge clk) begin
    logic [W+3:0] want;
    if (!rst && out_valid) begin
      if (exp_q.size() == 0) begin
        $display("out_valid went high at t=%0t with no beat in flight", $time);
        stop_on_failure();
      end else begin
        want = exp_q.pop_front();
        check("latency", edge_cnt - edge_q.pop_front(), LATENCY);
        check("result", result, want[W-1:0]);
        check("flags_out", W'(flags_out), W'(want[W+3:W]));
        n_checked++;
      end
    end
  end

  initial begin
    in_valid <= 1'b0;
    op       <= OP_ADD;
    cond     <= C_AL;
    else_sel <= ELSE_A;
    a        <= '0;
    b        <= '0;
    imm      <= '0;
    use_imm  <= 1'b0;
    flags_in <= 4'h0;
    wait_reset_release();
    idle(8);  // nothing may come out before the first beat
    run_arith();
    run_ops();
    run_cond_sweep();
    run_random(2000);
    idle(1);
    wait_drain();
    idle(4);
    if (exp_q.size() == 0 && n_checked == n_sent) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("%0d beats were sent but %0d results were checked", n_sent, n_checked);
      stop_on_failure();
    end
  end

endmodule

// ==== tb_clock.sv ====
/*
  Free-running testbench clock with a synchronous reset that stays high
  for the first RESET_CYCLES rising edges.
*/
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;  // released on an edge like any synchronous input
  end

endmodule
